/* fetch_pkg.sv */
package fetch_pkg;

	// ******************************
	// widths and address layout
	// ******************************

	localparam int ADDR_W = 64;
	localparam int INST_W = 32;
	// one memory word holds two instructions
	localparam int WORD_W = 64;
	localparam int WORD_OFS_W = 3;
	localparam logic [ADDR_W-1:0] RESET_PC = 64'h0000_0000_8000_0000;

	// direct-mapped icache, one word per line
	localparam int IC_LINES = 16;
	localparam int IC_IDX_W = $clog2(IC_LINES);
	localparam int IC_TAG_W = ADDR_W - IC_IDX_W - WORD_OFS_W;

	// backing memory, 0x8000_0000 .. 0x8000_07ff
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	// grant to rvalid, in cycles
	localparam int MEM_LATENCY = 2;
	localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 1);

	// predecode class of the presented instruction
	typedef enum logic [1:0] {
		CLS_SEQ,
		CLS_BRANCH,
		CLS_JAL
	} inst_class_e;

	// icache controller
	typedef enum logic {
		IC_LOOKUP,
		IC_REFILL
	} icache_state_e;

	// ******************************
	// address helpers
	// ******************************

	function automatic logic [IC_IDX_W-1:0] ic_index(input logic [ADDR_W-1:0] addr);
		return addr[WORD_OFS_W +: IC_IDX_W];
	endfunction

	function automatic logic [IC_TAG_W-1:0] ic_tag(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-1 -: IC_TAG_W];
	endfunction

	// drop the byte offset inside the word
	function automatic logic [ADDR_W-1:0] word_addr(input logic [ADDR_W-1:0] addr);
		return {addr[ADDR_W-1:WORD_OFS_W], {WORD_OFS_W{1'b0}}};
	endfunction

	function automatic logic [MEM_IDX_W-1:0] mem_index(input logic [ADDR_W-1:0] addr);
		return addr[WORD_OFS_W +: MEM_IDX_W];
	endfunction

endpackage

/* mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
	import fetch_pkg::*;

	// request side, held until gnt
	logic req;
	logic we;
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] wdata;

	// memory side
	// gnt is a one-cycle pulse, rvalid comes MEM_LATENCY cycles later for reads
	logic gnt;
	logic rvalid;
	logic [WORD_W-1:0] rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rvalid,
		input  rdata
	);

	modport memory (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rvalid,
		output rdata
	);

endinterface

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         redirect,
	input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
	input  logic                         inst_ready,
	input  logic                         fetch_rsp_valid,
	input  logic [fetch_pkg::INST_W-1:0] fetch_rsp_inst,
	output logic                         inst_valid,
	output logic [fetch_pkg::INST_W-1:0] inst,
	output logic [fetch_pkg::ADDR_W-1:0] inst_pc,
	output logic                         fetch_req,
	output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
	output logic                         fetch_kill
);
	import fetch_pkg::*;

	// address of the request in flight
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc_next;
	logic boot;
	logic booted;
	logic accept;

	inst_class_e cls;
	logic [ADDR_W-1:0] imm_b;
	logic [ADDR_W-1:0] imm_j;
	logic [ADDR_W-1:0] pred_pc;

	// ******************************
	// boot pulse
	// ******************************

	// single cycle, one cycle after rst falls
	always_ff @(posedge clk) begin
		if (rst) begin
			booted <= 1'b0;
			boot <= 1'b0;
		end else begin
			booted <= 1'b1;
			boot <= ~booted;
		end
	end

	// ******************************
	// predecode of the presented inst
	// ******************************

	always_comb begin
		cls = CLS_SEQ;
		if (inst[6:0] == 7'b1101111) begin
			cls = CLS_JAL;
		end else if (inst[6:0] == 7'b1100011 && inst[14:13] != 2'b01) begin
			// beq bne blt bge bltu bgeu, funct3 010/011 unused
			cls = CLS_BRANCH;
		end
	end

	// sign extended immediates
	assign imm_b = {{(ADDR_W-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{(ADDR_W-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// static prediction, backward branch taken
	always_comb begin
		case (cls)
			CLS_JAL: pred_pc = inst_pc + imm_j;
			CLS_BRANCH: pred_pc = imm_b[ADDR_W-1] ? inst_pc + imm_b : inst_pc + 64'd4;
			default: pred_pc = inst_pc + 64'd4;
		endcase
	end

	// ******************************
	// next pc and fetch request
	// ******************************

	assign accept = inst_valid & inst_ready;

	// redirect overrides any prediction
	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;
		end else if (accept) begin
			pc_next = pred_pc;
		end else begin
			pc_next = pc;
		end
	end

	// one outstanding request, next one goes out on acceptance
	assign fetch_req = boot | redirect | accept;
	assign fetch_pc = pc_next;
	// drop whatever the cache still owes us
	assign fetch_kill = redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (fetch_req) begin
			pc <= pc_next;
		end
	end

	// ******************************
	// output stage to decode
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
		end else if (redirect) begin
			// old path gone, response of this cycle too
			inst_valid <= 1'b0;
		end else if (fetch_rsp_valid) begin
			inst_valid <= 1'b1;
		end else if (accept) begin
			inst_valid <= 1'b0;
		end
	end

	// response only lands in an empty stage
	always_ff @(posedge clk) begin
		if (fetch_rsp_valid && !redirect) begin
			inst <= fetch_rsp_inst;
			inst_pc <= pc;
		end
	end

endmodule

/* icache.sv */
`timescale 1ns/1ps

module icache (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         fetch_req,
	input  logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
	input  logic                         fetch_kill,
	input  logic [fetch_pkg::ADDR_W-1:0] store_addr,
	input  logic                         store_done,
	output logic                         fetch_rsp_valid,
	output logic [fetch_pkg::INST_W-1:0] fetch_rsp_inst,
	mem_bus_if.requester                 refill
);
	import fetch_pkg::*;

	// line storage
	logic [WORD_W-1:0] data_q [IC_LINES];
	logic [IC_TAG_W-1:0] tag_q [IC_LINES];
	logic [IC_LINES-1:0] valid_q;

	icache_state_e state;
	// request that came in while refilling
	logic pend_valid;
	logic [ADDR_W-1:0] pend_pc;
	// refill in progress
	logic [ADDR_W-1:0] rf_pc;
	logic rf_live;
	logic rf_inval;
	logic req_q;

	logic lk_req;
	logic [ADDR_W-1:0] lk_pc;
	logic [WORD_W-1:0] lk_word;
	logic lk_hit;
	logic miss;
	logic fill;
	logic st_clear;
	logic st_on_lk;
	logic st_on_rf;

	// ******************************
	// lookup, same cycle as request
	// ******************************

	// new request wins over a parked one
	assign lk_req = (state == IC_LOOKUP) & (fetch_req | (pend_valid & ~fetch_kill));
	assign lk_pc = fetch_req ? fetch_pc : pend_pc;
	assign lk_word = data_q[ic_index(lk_pc)];
	assign lk_hit = valid_q[ic_index(lk_pc)] && (tag_q[ic_index(lk_pc)] == ic_tag(lk_pc));
	assign miss = lk_req & ~lk_hit;
	assign fill = (state == IC_REFILL) & refill.rvalid;

	// store checks
	assign st_clear = store_done && (tag_q[ic_index(store_addr)] == ic_tag(store_addr));
	assign st_on_lk = store_done && (word_addr(store_addr) == word_addr(lk_pc));
	assign st_on_rf = store_done && (word_addr(store_addr) == word_addr(rf_pc));

	// refill is always a word read
	assign refill.req = req_q;
	assign refill.we = 1'b0;
	assign refill.addr = word_addr(rf_pc);
	assign refill.wdata = '0;

	// ******************************
	// controller
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IC_LOOKUP;
			req_q <= 1'b0;
			rf_live <= 1'b0;
			rf_inval <= 1'b0;
			pend_valid <= 1'b0;
			fetch_rsp_valid <= 1'b0;
		end else begin
			fetch_rsp_valid <= 1'b0;
			case (state)
				IC_LOOKUP: begin
					// parked request is served or killed here
					pend_valid <= 1'b0;
					if (lk_req && lk_hit) begin
						fetch_rsp_valid <= 1'b1;
					end else if (miss) begin
						state <= IC_REFILL;
						req_q <= 1'b1;
						rf_live <= 1'b1;
						rf_inval <= st_on_lk;
					end
				end
				IC_REFILL: begin
					if (refill.gnt) begin
						req_q <= 1'b0;
					end
					// killed refill still lands in the array
					if (fetch_kill) begin
						rf_live <= 1'b0;
					end
					if (st_on_rf) begin
						rf_inval <= 1'b1;
					end
					if (fetch_req) begin
						pend_valid <= 1'b1;
					end else if (fetch_kill) begin
						pend_valid <= 1'b0;
					end
					if (refill.rvalid) begin
						state <= IC_LOOKUP;
						fetch_rsp_valid <= rf_live & ~fetch_kill;
					end
				end
				default: state <= IC_LOOKUP;
			endcase
		end
	end

	// valid bits, store clear beats refill set
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			if (fill && !rf_inval && !st_on_rf) begin
				valid_q[ic_index(rf_pc)] <= 1'b1;
			end
			if (st_clear) begin
				valid_q[ic_index(store_addr)] <= 1'b0;
			end
		end
	end

	// payload and arrays
	always_ff @(posedge clk) begin
		if (miss) begin
			rf_pc <= lk_pc;
		end
		if (state == IC_REFILL && fetch_req) begin
			pend_pc <= fetch_pc;
		end
		if (fill) begin
			data_q[ic_index(rf_pc)] <= refill.rdata;
			tag_q[ic_index(rf_pc)] <= ic_tag(rf_pc);
			fetch_rsp_inst <= rf_pc[2] ? refill.rdata[63:32] : refill.rdata[31:0];
		end else if (lk_req) begin
			// pc bit 2 picks the half
			fetch_rsp_inst <= lk_pc[2] ? lk_word[63:32] : lk_word[31:0];
		end
	end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input logic clk,
	input logic rst,
	mem_bus_if.memory store_port,
	mem_bus_if.memory refill_port,
	mem_bus_if.requester mem
);

	// 0 store, 1 refill
	logic sel;
	// read outstanding, owner gets rvalid
	logic busy;
	logic owner;

	// ******************************
	// fixed priority, store first
	// ******************************

	assign sel = ~store_port.req;

	// nothing new while a read is out
	assign mem.req = ~busy & (store_port.req | refill_port.req);
	assign mem.we = sel ? refill_port.we : store_port.we;
	assign mem.addr = sel ? refill_port.addr : store_port.addr;
	assign mem.wdata = sel ? refill_port.wdata : store_port.wdata;

	// grant back to the winner only
	assign store_port.gnt = mem.gnt & ~sel;
	assign refill_port.gnt = mem.gnt & sel;

	// read data back to whoever was granted
	assign store_port.rvalid = mem.rvalid & ~owner;
	assign refill_port.rvalid = mem.rvalid & owner;
	assign store_port.rdata = mem.rdata;
	assign refill_port.rdata = mem.rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			owner <= 1'b0;
		end else if (mem.gnt && !mem.we) begin
			busy <= 1'b1;
			owner <= sel;
		end else if (mem.rvalid) begin
			busy <= 1'b0;
		end
	end

endmodule

/* inst_mem.sv */
`timescale 1ns/1ps

module inst_mem (
	input logic clk,
	input logic rst,
	mem_bus_if.memory bus
);
	import fetch_pkg::*;

	logic [WORD_W-1:0] mem_q [MEM_WORDS];
	// cycles left until read data
	logic [LAT_CNT_W-1:0] cnt;
	logic [WORD_W-1:0] rdata_q;

	// idle memory grants in the request cycle
	assign bus.gnt = bus.req & (cnt == '0);
	assign bus.rvalid = (cnt == LAT_CNT_W'(1));
	assign bus.rdata = rdata_q;

	// ******************************
	// read latency counter
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (bus.gnt && !bus.we) begin
			cnt <= LAT_CNT_W'(MEM_LATENCY);
		end else if (cnt != '0) begin
			cnt <= cnt - LAT_CNT_W'(1);
		end
	end

	// write at grant, read word captured at grant
	always_ff @(posedge clk) begin
		if (bus.gnt && bus.we) begin
			mem_q[mem_index(bus.addr)] <= bus.wdata;
		end
		if (bus.gnt && !bus.we) begin
			rdata_q <= mem_q[mem_index(bus.addr)];
		end
	end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         redirect,
	input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
	input  logic                         inst_ready,
	input  logic                         store_valid,
	input  logic [fetch_pkg::ADDR_W-1:0] store_addr,
	input  logic [fetch_pkg::WORD_W-1:0] store_data,
	output logic                         inst_valid,
	output logic [fetch_pkg::INST_W-1:0] inst,
	output logic [fetch_pkg::ADDR_W-1:0] inst_pc,
	output logic                         store_done
);
	import fetch_pkg::*;

	mem_bus_if store_bus ();
	mem_bus_if refill_bus ();
	mem_bus_if mem_bus ();

	// fetch unit to icache
	logic fetch_req;
	logic [ADDR_W-1:0] fetch_pc;
	logic fetch_kill;
	logic fetch_rsp_valid;
	logic [INST_W-1:0] fetch_rsp_inst;

	// store port is a write-only requester
	assign store_bus.req = store_valid;
	assign store_bus.we = 1'b1;
	assign store_bus.addr = store_addr;
	assign store_bus.wdata = store_data;
	assign store_done = store_bus.gnt;

	fetch_unit u_fetch (
		.clk             (clk),
		.rst             (rst),
		.redirect        (redirect),
		.redirect_pc     (redirect_pc),
		.inst_ready      (inst_ready),
		.fetch_rsp_valid (fetch_rsp_valid),
		.fetch_rsp_inst  (fetch_rsp_inst),
		.inst_valid      (inst_valid),
		.inst            (inst),
		.inst_pc         (inst_pc),
		.fetch_req       (fetch_req),
		.fetch_pc        (fetch_pc),
		.fetch_kill      (fetch_kill)
	);

	icache u_icache (
		.clk             (clk),
		.rst             (rst),
		.fetch_req       (fetch_req),
		.fetch_pc        (fetch_pc),
		.fetch_kill      (fetch_kill),
		.store_addr      (store_addr),
		.store_done      (store_done),
		.fetch_rsp_valid (fetch_rsp_valid),
		.fetch_rsp_inst  (fetch_rsp_inst),
		.refill          (refill_bus)
	);

	// port 0 store, port 1 refill
	mem_arbiter u_arb (
		.clk         (clk),
		.rst         (rst),
		.store_port  (store_bus),
		.refill_port (refill_bus),
		.mem         (mem_bus)
	);

	inst_mem u_mem (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus)
	);

endmodule

/* fetch_assert.sv */
`timescale 1ns/1ps

module fetch_assert (
	input logic                            clk,
	input logic                            rst,
	input logic                            redirect,
	input logic                            inst_valid,
	input logic                            inst_ready,
	input logic [fetch_pkg::INST_W-1:0]    inst,
	input logic [fetch_pkg::ADDR_W-1:0]    inst_pc,
	input logic                            refill_req,
	input logic                            refill_gnt,
	input logic                            refill_rvalid,
	input fetch_pkg::icache_state_e        ic_state
);
	import fetch_pkg::*;

	// decode side holds while stalled
	a_hold: assert property (@(posedge clk) disable iff (rst)
		(inst_valid && !inst_ready && !redirect) |=>
		(inst_valid && $stable(inst) && $stable(inst_pc)))
		else $error("fetch output changed under back-pressure");

	// no grant without a request
	a_refill_gnt: assert property (@(posedge clk) disable iff (rst) refill_gnt |-> refill_req)
		else $error("refill grant without request");

	// read data only comes back while the cache waits for it
	a_refill_data: assert property (@(posedge clk) disable iff (rst)
		refill_rvalid |-> (ic_state == IC_REFILL))
		else $error("refill data outside refill state");

	a_redirect: assert property (@(posedge clk) disable iff (rst) redirect |=> !inst_valid)
		else $error("inst_valid high after redirect");

endmodule

bind fetch_top fetch_assert u_fetch_assert (
	.clk           (clk),
	.rst           (rst),
	.redirect      (redirect),
	.inst_valid    (inst_valid),
	.inst_ready    (inst_ready),
	.inst          (inst),
	.inst_pc       (inst_pc),
	.refill_req    (refill_bus.req),
	.refill_gnt    (refill_bus.gnt),
	.refill_rvalid (refill_bus.rvalid),
	.ic_state      (u_icache.state)
);

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		STEP_STORE,
		STEP_EXPECT,
		STEP_REDIRECT,
		STEP_STALL
	} step_e;

	typedef struct packed {
		step_e kind;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic [15:0] cnt;
	} step_t;

	localparam int N_ROWS = 19;
	localparam int CYCLE_LIMIT = 40 * N_ROWS + 200;
	localparam logic [31:0] NOP = 32'h0000_0013;
	localparam logic [31:0] ADDI1 = 32'h0010_8093;

	logic clk;
	logic rst;
	logic redirect;
	logic [ADDR_W-1:0] redirect_pc;
	logic inst_ready;
	logic store_valid;
	logic [ADDR_W-1:0] store_addr;
	logic [WORD_W-1:0] store_data;
	logic inst_valid;
	logic [INST_W-1:0] inst;
	logic [ADDR_W-1:0] inst_pc;
	logic store_done;

	// reference state
	logic [WORD_W-1:0] image [MEM_WORDS];
	logic [ADDR_W-1:0] exp_pc;
	logic [31:0] rnd;
	step_t steps [N_ROWS];
	int cycles;
	int stores_sent;
	int done_seen;

	fetch_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// B-type with rs2 = x0
	function automatic logic [31:0] branch_inst(input logic [12:0] imm, input logic [4:0] rs1,
			input logic [2:0] funct3);
		return {imm[12], imm[10:5], 5'd0, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	// J-type with rd = x0
	function automatic logic [31:0] jal_inst(input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
	endfunction

	// instruction the model expects at a pc
	function automatic logic [31:0] image_inst(input logic [ADDR_W-1:0] pc);
		logic [WORD_W-1:0] w;
		w = image[mem_index(pc)];
		return pc[2] ? w[63:32] : w[31:0];
	endfunction

	// jal and backward branch taken, the rest falls through
	function automatic logic [ADDR_W-1:0] predict(input logic [ADDR_W-1:0] pc,
			input logic [31:0] ins);
		logic [12:0] b;
		logic [20:0] j;
		b = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		j = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		if (ins[6:0] == 7'b1101111) begin
			return pc + {{(ADDR_W-21){j[20]}}, j};
		end
		if (ins[6:0] == 7'b1100011 && b[12]) begin
			return pc + {{(ADDR_W-13){b[12]}}, b};
		end
		return pc + 64'd4;
	endfunction

	function automatic step_t make_step(input step_e k, input logic [11:0] ofs,
			input logic [WORD_W-1:0] d, input logic [15:0] n);
		step_t s;
		s.kind = k;
		s.addr = RESET_PC + {52'd0, ofs};
		s.data = d;
		s.cnt = n;
		return s;
	endfunction

	task automatic check_value(input string what, input logic [63:0] act,
			input logic [63:0] exp);
		if (act !== exp) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, act, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// ******************************
	// step tasks
	// ******************************

	// store_valid stays up into the next store row
	task automatic store_word(input logic [ADDR_W-1:0] a, input logic [WORD_W-1:0] d);
		@(negedge clk);
		redirect = 1'b0;
		inst_ready = 1'b0;
		store_valid = 1'b1;
		store_addr = a;
		store_data = d;
		#1;
		while (!store_done) begin
			@(negedge clk);
			#1;
		end
		image[mem_index(a)] = d;
		stores_sent++;
	endtask

	task automatic expect_insts(input int n);
		int got;
		logic [31:0] ins;
		got = 0;
		while (got < n) begin
			@(negedge clk);
			store_valid = 1'b0;
			redirect = 1'b0;
			rnd = xorshift(rnd);
			inst_ready = (rnd[1:0] != 2'b00);
			#1;
			if (inst_valid && inst_ready) begin
				ins = image_inst(exp_pc);
				check_value("inst_pc", inst_pc, exp_pc);
				check_value("inst", {32'd0, inst}, {32'd0, ins});
				exp_pc = predict(exp_pc, ins);
				got++;
			end
		end
	endtask

	task automatic apply_redirect(input logic [ADDR_W-1:0] a);
		@(negedge clk);
		store_valid = 1'b0;
		inst_ready = 1'b0;
		redirect = 1'b1;
		redirect_pc = a;
		exp_pc = a;
		@(negedge clk);
		redirect = 1'b0;
		#1;
		check_value("inst_valid after redirect", {63'd0, inst_valid}, 64'd0);
	endtask

	task automatic stall_ready(input int k);
		repeat (k) begin
			@(negedge clk);
			store_valid = 1'b0;
			redirect = 1'b0;
			inst_ready = 1'b0;
		end
	endtask

	// ******************************
	// monitors
	// ******************************

	// one store_done sample per cycle
	initial begin
		done_seen = 0;
		forever begin
			@(negedge clk);
			#2;
			if (!rst && store_done) begin
				done_seen++;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end

	// ******************************
	// main sequence
	// ******************************

	initial begin
		rst = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		inst_ready = 1'b0;
		store_valid = 1'b0;
		store_addr = '0;
		store_data = '0;
		rnd = 32'he576_c852;
		exp_pc = RESET_PC;
		stores_sent = 0;

		// program with seq, forward beq, jal and a backward bne loop
		steps[0] = make_step(STEP_STORE, 12'h000, {ADDI1, NOP}, 16'd0);
		steps[1] = make_step(STEP_STORE, 12'h008, {branch_inst(13'd8, 5'd0, 3'b000), NOP},
			16'd0);
		steps[2] = make_step(STEP_STORE, 12'h010, {32'h0020_0113, jal_inst(21'd16)}, 16'd0);
		steps[3] = make_step(STEP_STORE, 12'h018, {32'h0030_0193, 32'h0030_0193}, 16'd0);
		steps[4] = make_step(STEP_STORE, 12'h020, {ADDI1, NOP}, 16'd0);
		steps[5] = make_step(STEP_STORE, 12'h028, {NOP, branch_inst(-13'sd8, 5'd1, 3'b001)},
			16'd0);
		// second region on lines 0 and 1 with a jal back loop
		steps[6] = make_step(STEP_STORE, 12'h100, {32'h0060_0313, 32'h0050_0293}, 16'd0);
		steps[7] = make_step(STEP_STORE, 12'h108, {NOP, jal_inst(-21'sd8)}, 16'd0);
		steps[8] = make_step(STEP_EXPECT, 12'h000, '0, 16'd12);
		steps[9] = make_step(STEP_STALL, 12'h000, '0, 16'd5);
		steps[10] = make_step(STEP_EXPECT, 12'h000, '0, 16'd6);
		steps[11] = make_step(STEP_REDIRECT, 12'h100, '0, 16'd0);
		steps[12] = make_step(STEP_EXPECT, 12'h000, '0, 16'd8);
		steps[13] = make_step(STEP_STALL, 12'h000, '0, 16'd3);
		// overwrite a cached word and go back to it
		steps[14] = make_step(STEP_STORE, 12'h100, {32'h0080_0413, 32'h0070_0393}, 16'd0);
		steps[15] = make_step(STEP_REDIRECT, 12'h100, '0, 16'd0);
		steps[16] = make_step(STEP_EXPECT, 12'h000, '0, 16'd6);
		steps[17] = make_step(STEP_REDIRECT, 12'h008, '0, 16'd0);
		steps[18] = make_step(STEP_EXPECT, 12'h000, '0, 16'd10);

		repeat (8) @(negedge clk);
		rst = 1'b0;
		#1;
		check_value("inst_valid after reset", {63'd0, inst_valid}, 64'd0);
		check_value("store_done after reset", {63'd0, store_done}, 64'd0);

		for (int i = 0; i < N_ROWS; i++) begin
			case (steps[i].kind)
				STEP_STORE: store_word(steps[i].addr, steps[i].data);
				STEP_EXPECT: expect_insts(int'(steps[i].cnt));
				STEP_REDIRECT: apply_redirect(steps[i].addr);
				default: stall_ready(int'(steps[i].cnt));
			endcase
		end

		stall_ready(2);
		check_value("store_done pulses", 64'(done_seen), 64'(stores_sent));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* fetch_top.f */
fetch_pkg.sv
mem_bus_if.sv
fetch_unit.sv
icache.sv
mem_arbiter.sv
inst_mem.sv
fetch_top.sv
fetch_assert.sv
tb_fetch_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f fetch_top.f \
	--top-module tb_fetch_top \
	--Mdir obj_dir \
	-o sim_fetch
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_fetch
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
